// ==== logic/video_pkg.sv ====
// Video geometry and pixel types for the scroll layer
// Map entry layout and graphics ROM word layout
`default_nettype none

package video_pkg;

    typedef logic [8:0]  coord_t;     // Screen or plane position, plane wraps at 512
    typedef logic [9:0]  tile_id_t;
    typedef logic [3:0]  pal_t;       // Palette bank
    typedef logic [3:0]  color_t;     // Pixel color within a bank
    typedef logic [7:0]  pal_idx_t;   // {bank, color}
    typedef logic [11:0] rgb_t;       // 4 bits per channel

    // {vflip, hflip, bank, tile id}
    typedef logic [15:0] map_entry_t;
    typedef logic [9:0]  map_addr_t;  // {tile row, tile column}
    typedef logic [15:0] rom_addr_t;  // {tile id, row in tile, quarter of row}
    typedef logic [15:0] rom_word_t;  // One nibble per plane, plane 3 on top

    // Map entry fields
    localparam int PAL_LSB   = 10;
    localparam int HFLIP_BIT = 14;
    localparam int VFLIP_BIT = 15;

endpackage

`default_nettype wire

// ==== logic/axi_pkg.sv ====
// AXI4-Lite bus types and response codes
// Register address map of the scroll layer
`default_nettype none

package axi_pkg;

    typedef logic [15:0] axi_addr_t;  // Byte address
    typedef logic [31:0] axi_data_t;
    typedef logic [1:0]  axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'd0;
    localparam axi_resp_t RESP_SLVERR = 2'd2;
    localparam axi_resp_t RESP_DECERR = 2'd3;

    localparam axi_addr_t REG_CTRL     = 16'h0000; // Bit 0 enables the layer
    localparam axi_addr_t REG_SCROLL_X = 16'h0004; // 9 bits
    localparam axi_addr_t REG_SCROLL_Y = 16'h0008; // 9 bits

    // Write-only memory windows, end addresses exclusive
    localparam axi_addr_t MAP_BASE = 16'h1000; // 1024 words, data 15..0
    localparam axi_addr_t MAP_END  = 16'h2000;
    localparam axi_addr_t PAL_BASE = 16'h2000; // 256 words, data 11..0
    localparam axi_addr_t PAL_END  = 16'h2400;

endpackage

`default_nettype wire

// ==== logic/cpu_regs.sv ====
// AXI4-Lite slave for the scroll layer
// Control and scroll registers, write ports into tile map and palette
`timescale 1ns/1ns
`default_nettype none

module cpu_regs (
    input  wire                     clk,
    input  wire                     rst,
    input  wire axi_pkg::axi_addr_t awaddr,
    input  wire                     awvalid,
    output logic                    awready,
    input  wire axi_pkg::axi_data_t wdata,
    input  wire                     wvalid,
    output logic                    wready,
    output axi_pkg::axi_resp_t      bresp,
    output logic                    bvalid,
    input  wire                     bready,
    input  wire axi_pkg::axi_addr_t araddr,
    input  wire                     arvalid,
    output logic                    arready,
    output axi_pkg::axi_data_t      rdata,
    output axi_pkg::axi_resp_t      rresp,
    output logic                    rvalid,
    input  wire                     rready,
    output logic                    layer_on,
    output video_pkg::coord_t       scroll_x,
    output video_pkg::coord_t       scroll_y,
    output logic                    map_we,
    output video_pkg::map_addr_t    map_waddr,
    output video_pkg::map_entry_t   map_wdata,
    output logic                    pal_we,
    output video_pkg::pal_idx_t     pal_waddr,
    output video_pkg::rgb_t         pal_wdata
);

    typedef enum logic {W_IDLE, W_RESP} write_state_t;
    typedef enum logic {R_IDLE, R_DATA} read_state_t;

    write_state_t w_state;
    read_state_t  r_state;
    logic         wr_go;    // Write accepted this cycle
    logic         rd_go;    // Read accepted this cycle
    logic         wr_map;
    logic         wr_pal;

    function automatic logic in_range(axi_pkg::axi_addr_t a, axi_pkg::axi_addr_t lo,
                                      axi_pkg::axi_addr_t hi);
        return (a >= lo) && (a < hi);
    endfunction

    function automatic logic is_reg(axi_pkg::axi_addr_t a);
        return (a == axi_pkg::REG_CTRL) || (a == axi_pkg::REG_SCROLL_X) ||
               (a == axi_pkg::REG_SCROLL_Y);
    endfunction

    // Address and data taken together, only with no response pending
    assign wr_go   = (w_state == W_IDLE) && awvalid && wvalid;
    assign awready = wr_go;
    assign wready  = wr_go;
    assign bvalid  = (w_state == W_RESP);
    assign rd_go   = (r_state == R_IDLE) && arvalid;
    assign arready = (r_state == R_IDLE);
    assign rvalid  = (r_state == R_DATA);

    assign wr_map = in_range(awaddr, axi_pkg::MAP_BASE, axi_pkg::MAP_END);
    assign wr_pal = in_range(awaddr, axi_pkg::PAL_BASE, axi_pkg::PAL_END);

    // Memory writes pulse on the acceptance cycle, word addressed
    assign map_we    = wr_go && wr_map;
    assign map_waddr = awaddr[11:2];
    assign map_wdata = wdata[15:0];
    assign pal_we    = wr_go && wr_pal;
    assign pal_waddr = awaddr[9:2];
    assign pal_wdata = wdata[11:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            w_state  <= W_IDLE;
            layer_on <= 1'b0;
            scroll_x <= '0;
            scroll_y <= '0;
        end else if (wr_go) begin
            w_state <= W_RESP;
            case (awaddr)
                axi_pkg::REG_CTRL:     layer_on <= wdata[0];
                axi_pkg::REG_SCROLL_X: scroll_x <= wdata[8:0];
                axi_pkg::REG_SCROLL_Y: scroll_y <= wdata[8:0];
                default: ;                               // Map, palette or unmapped
            endcase
        end else if (bvalid && bready) begin
            w_state <= W_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r_state <= R_IDLE;
        end else if (rd_go) begin
            r_state <= R_DATA;
        end else if (rvalid && rready) begin
            r_state <= R_IDLE;
        end
    end

    // Response payload, held while the response waits
    always_ff @(posedge clk) begin
        if (wr_go) begin
            bresp <= (is_reg(awaddr) || wr_map || wr_pal) ? axi_pkg::RESP_OKAY
                                                          : axi_pkg::RESP_DECERR;
        end
        if (rd_go) begin
            rdata <= '0;
            rresp <= axi_pkg::RESP_DECERR;
            case (araddr)
                axi_pkg::REG_CTRL: begin
                    rdata <= axi_pkg::axi_data_t'(layer_on);
                    rresp <= axi_pkg::RESP_OKAY;
                end
                axi_pkg::REG_SCROLL_X: begin
                    rdata <= axi_pkg::axi_data_t'(scroll_x);
                    rresp <= axi_pkg::RESP_OKAY;
                end
                axi_pkg::REG_SCROLL_Y: begin
                    rdata <= axi_pkg::axi_data_t'(scroll_y);
                    rresp <= axi_pkg::RESP_OKAY;
                end
                default: begin
                    // Map and palette cannot be read back
                    if (in_range(araddr, axi_pkg::MAP_BASE, axi_pkg::PAL_END)) begin
                        rresp <= axi_pkg::RESP_SLVERR;
                    end
                end
            endcase
        end
    end

    // Responses hold, unchanged, until taken
    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp));
    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

// ==== logic/scan_counter.sv ====
// Raster counters with sync and display enable
// Scroll and layer enable latched once per frame
`timescale 1ns/1ns
`default_nettype none

module scan_counter #(
    parameter int H_ACTIVE = 256,
    parameter int H_TOTAL  = 320,
    parameter int V_ACTIVE = 224,
    parameter int V_TOTAL  = 262
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    layer_on,
    input  wire video_pkg::coord_t scroll_x,
    input  wire video_pkg::coord_t scroll_y,
    output video_pkg::map_addr_t   map_raddr,
    output logic [3:0]             sx_lo,    // Column inside the tile
    output logic [3:0]             sy_lo,    // Row inside the tile
    output logic                   line_on,
    output logic                   de,
    output logic                   hsync,
    output logic                   vsync
);

    localparam video_pkg::coord_t H_LAST   = video_pkg::coord_t'(H_TOTAL - 1);
    localparam video_pkg::coord_t V_LAST   = video_pkg::coord_t'(V_TOTAL - 1);
    localparam video_pkg::coord_t H_DE     = video_pkg::coord_t'(H_ACTIVE);
    localparam video_pkg::coord_t V_DE     = video_pkg::coord_t'(V_ACTIVE);
    localparam video_pkg::coord_t HS_FIRST = video_pkg::coord_t'(H_ACTIVE + 8);
    localparam video_pkg::coord_t HS_LAST  = video_pkg::coord_t'(H_ACTIVE + 16);
    localparam video_pkg::coord_t VS_LINE  = video_pkg::coord_t'(V_ACTIVE + 2);

    video_pkg::coord_t h;         // Count state, cycle 0 of the pipeline
    video_pkg::coord_t v;
    video_pkg::coord_t sx_lat;    // Scroll in use for this frame
    video_pkg::coord_t sy_lat;
    logic              on_lat;
    video_pkg::coord_t px;        // Position on the 512x512 plane
    video_pkg::coord_t py;
    logic              frame_end;

    assign frame_end = (h == H_LAST) && (v == V_LAST);
    assign px        = h + sx_lat;   // Wraps modulo 512
    assign py        = v + sy_lat;
    assign map_raddr = {py[8:4], px[8:4]};  // Map RAM registers it

    always_ff @(posedge clk) begin
        if (rst) begin
            h      <= '0;
            v      <= '0;
            sx_lat <= '0;
            sy_lat <= '0;
            on_lat <= 1'b0;
        end else begin
            h <= (h == H_LAST) ? '0 : h + 1'b1;
            if (h == H_LAST) begin
                v <= (v == V_LAST) ? '0 : v + 1'b1;
            end
            if (frame_end) begin   // New values from the next frame's first pixel
                sx_lat <= scroll_x;
                sy_lat <= scroll_y;
                on_lat <= layer_on;
            end
        end
    end

    // Side band registered to line up with the map entry
    always_ff @(posedge clk) begin
        if (rst) begin
            line_on <= 1'b0;
            de      <= 1'b0;
            hsync   <= 1'b0;
            vsync   <= 1'b0;
        end else begin
            line_on <= on_lat;
            de      <= (h < H_DE) && (v < V_DE);
            hsync   <= (h >= HS_FIRST) && (h <= HS_LAST);  // 9 pixels wide
            vsync   <= (v == VS_LINE);
        end
        sx_lo <= px[3:0];
        sy_lo <= py[3:0];
    end

    a_h_range: assert property (@(posedge clk) disable iff (rst) h <= H_LAST);

endmodule

`default_nettype wire

// ==== logic/tile_map_ram.sv ====
// Tile map memory, 1024 entries of 16 bits
// Bus write port and registered pipeline read port
`timescale 1ns/1ns
`default_nettype none

module tile_map_ram (
    input  wire                        clk,
    input  wire                        map_we,
    input  wire video_pkg::map_addr_t  map_waddr,
    input  wire video_pkg::map_entry_t map_wdata,
    input  wire video_pkg::map_addr_t  map_raddr,
    output video_pkg::map_entry_t      entry
);

    video_pkg::map_entry_t mem [0:1023];   // 32x32 tiles covering the plane

    always_ff @(posedge clk) begin
        if (map_we) begin
            mem[map_waddr] <= map_wdata;
        end
        entry <= mem[map_raddr];   // Valid at cycle 1
    end

endmodule

`default_nettype wire

// ==== logic/tile_fetch.sv ====
// Graphics ROM address stage
// Applies tile flips, splits the column into ROM quarter and pixel select
`timescale 1ns/1ns
`default_nettype none

module tile_fetch (
    input  wire                        clk,
    input  wire video_pkg::map_entry_t entry,
    input  wire [3:0]                  sx_lo,
    input  wire [3:0]                  sy_lo,
    input  wire                        line_on,
    input  wire                        de,
    input  wire                        hsync,
    input  wire                        vsync,
    output video_pkg::rom_addr_t       rom_addr,
    output video_pkg::pal_t            pal,
    output logic                       hflip,
    output logic [1:0]                 px_sel,   // Pixel within the ROM word
    output logic                       line_on_d,
    output logic                       de_d,
    output logic                       hsync_d,
    output logic                       vsync_d
);

    video_pkg::tile_id_t tile;
    logic [3:0]          row;   // Row inside the tile after vflip
    logic [3:0]          col;   // Column inside the tile after hflip

    assign tile = entry[9:0];
    assign row  = sy_lo ^ {4{entry[video_pkg::VFLIP_BIT]}};
    assign col  = sx_lo ^ {4{entry[video_pkg::HFLIP_BIT]}};

    always_ff @(posedge clk) begin
        rom_addr  <= {tile, row, col[3:2]};   // Cycle 2
        pal       <= entry[video_pkg::PAL_LSB +: 4];
        hflip     <= entry[video_pkg::HFLIP_BIT];
        px_sel    <= col[1:0];                // Already flipped
        line_on_d <= line_on;
        de_d      <= de;
        hsync_d   <= hsync;
        vsync_d   <= vsync;
    end

endmodule

`default_nettype wire

// ==== logic/tile_pixel.sv ====
// Pixel select from the graphics ROM word
// Palette index forming, forced to the last entry with the layer off
`timescale 1ns/1ns
`default_nettype none

module tile_pixel (
    input  wire                       clk,
    input  wire video_pkg::rom_word_t rom_data,
    input  wire video_pkg::pal_t      pal,
    input  wire [1:0]                 px_sel,
    input  wire                       line_on,
    input  wire                       de,
    input  wire                       hsync,
    input  wire                       vsync,
    output video_pkg::pal_idx_t       pal_raddr,
    output logic                      de_d,
    output logic                      hsync_d,
    output logic                      vsync_d
);

    video_pkg::pal_t    pal_q;    // Side band aligned with rom_data, cycle 3
    logic [1:0]         sel_q;
    logic               on_q;
    logic               de_q;
    logic               hsync_q;
    logic               vsync_q;
    video_pkg::color_t  color;

    always_ff @(posedge clk) begin
        pal_q   <= pal;
        sel_q   <= px_sel;
        on_q    <= line_on;
        de_q    <= de;
        hsync_q <= hsync;
        vsync_q <= vsync;
    end

    // Nibble bit 3 is the leftmost pixel, so bit index is 3 - sel
    assign color = {rom_data[{2'd3, ~sel_q}], rom_data[{2'd2, ~sel_q}],
                    rom_data[{2'd1, ~sel_q}], rom_data[{2'd0, ~sel_q}]};

    always_ff @(posedge clk) begin
        pal_raddr <= on_q ? {pal_q, color} : 8'hFF;   // Cycle 4
        de_d      <= de_q;
        hsync_d   <= hsync_q;
        vsync_d   <= vsync_q;
    end

endmodule

`default_nettype wire

// ==== logic/palette_ram.sv ====
// Palette memory, 256 entries of 12-bit RGB
// Final output register with matching sync delay
`timescale 1ns/1ns
`default_nettype none

module palette_ram (
    input  wire                      clk,
    input  wire                      pal_we,
    input  wire video_pkg::pal_idx_t pal_waddr,
    input  wire video_pkg::rgb_t     pal_wdata,
    input  wire video_pkg::pal_idx_t pal_raddr,
    input  wire                      de_in,
    input  wire                      hsync_in,
    input  wire                      vsync_in,
    output video_pkg::rgb_t          rgb,
    output logic                     de,
    output logic                     hsync,
    output logic                     vsync
);

    video_pkg::rgb_t mem [0:255];   // 16 banks of 16 colors

    always_ff @(posedge clk) begin
        if (pal_we) begin
            mem[pal_waddr] <= pal_wdata;
        end
        rgb   <= mem[pal_raddr];   // Cycle 5
        de    <= de_in;
        hsync <= hsync_in;
        vsync <= vsync_in;
    end

endmodule

`default_nettype wire

// ==== logic/scroll_layer.sv ====
// Scrolling tile layer, 16x16 tiles at 4 bits per pixel
// Bus registers, raster timing and the five-stage pixel pipeline
`timescale 1ns/1ns
`default_nettype none

module scroll_layer #(
    parameter int H_ACTIVE = 256,
    parameter int H_TOTAL  = 320,
    parameter int V_ACTIVE = 224,
    parameter int V_TOTAL  = 262
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire axi_pkg::axi_addr_t   awaddr,
    input  wire                       awvalid,
    output logic                      awready,
    input  wire axi_pkg::axi_data_t   wdata,
    input  wire                       wvalid,
    output logic                      wready,
    output axi_pkg::axi_resp_t        bresp,
    output logic                      bvalid,
    input  wire                       bready,
    input  wire axi_pkg::axi_addr_t   araddr,
    input  wire                       arvalid,
    output logic                      arready,
    output axi_pkg::axi_data_t        rdata,
    output axi_pkg::axi_resp_t        rresp,
    output logic                      rvalid,
    input  wire                       rready,
    output video_pkg::rom_addr_t      rom_addr,   // External ROM, one cycle read
    input  wire video_pkg::rom_word_t rom_data,
    output video_pkg::rgb_t           rgb,
    output logic                      de,
    output logic                      hsync,
    output logic                      vsync
);

    logic                  layer_on;
    video_pkg::coord_t     scroll_x;
    video_pkg::coord_t     scroll_y;
    logic                  map_we;
    video_pkg::map_addr_t  map_waddr;
    video_pkg::map_entry_t map_wdata;
    logic                  pal_we;
    video_pkg::pal_idx_t   pal_waddr;
    video_pkg::rgb_t       pal_wdata;
    video_pkg::map_addr_t  map_raddr;
    video_pkg::map_entry_t entry;       // Cycle 1
    logic [3:0]            sx_lo;
    logic [3:0]            sy_lo;
    logic                  c1_on, c1_de, c1_hs, c1_vs;
    video_pkg::pal_t       pal;         // Cycle 2
    logic [1:0]            px_sel;
    logic                  c2_on, c2_de, c2_hs, c2_vs;
    video_pkg::pal_idx_t   pal_raddr;   // Cycle 4
    logic                  c4_de, c4_hs, c4_vs;

    cpu_regs u_regs (
        .clk, .rst, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready, .layer_on, .scroll_x, .scroll_y,
        .map_we, .map_waddr, .map_wdata, .pal_we, .pal_waddr, .pal_wdata
    );

    scan_counter #(
        .H_ACTIVE (H_ACTIVE), .H_TOTAL (H_TOTAL),
        .V_ACTIVE (V_ACTIVE), .V_TOTAL (V_TOTAL)
    ) u_scan (
        .clk, .rst, .layer_on, .scroll_x, .scroll_y, .map_raddr, .sx_lo, .sy_lo,
        .line_on (c1_on), .de (c1_de), .hsync (c1_hs), .vsync (c1_vs)
    );

    tile_map_ram u_map (.clk, .map_we, .map_waddr, .map_wdata, .map_raddr, .entry);

    tile_fetch u_fetch (
        .clk, .entry, .sx_lo, .sy_lo,
        .line_on (c1_on), .de (c1_de), .hsync (c1_hs), .vsync (c1_vs),
        .rom_addr, .pal, .hflip (), .px_sel,   // Flip already folded into px_sel
        .line_on_d (c2_on), .de_d (c2_de), .hsync_d (c2_hs), .vsync_d (c2_vs)
    );

    tile_pixel u_pixel (
        .clk, .rom_data, .pal, .px_sel,
        .line_on (c2_on), .de (c2_de), .hsync (c2_hs), .vsync (c2_vs),
        .pal_raddr, .de_d (c4_de), .hsync_d (c4_hs), .vsync_d (c4_vs)
    );

    palette_ram u_pal (
        .clk, .pal_we, .pal_waddr, .pal_wdata, .pal_raddr,
        .de_in (c4_de), .hsync_in (c4_hs), .vsync_in (c4_vs),
        .rgb, .de, .hsync, .vsync
    );

endmodule

`default_nettype wire

// ==== testbench/tb_tasks.svh ====
// AXI4-Lite driver tasks, frame capture and compare
// Six directed tests of the scroll layer
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_field(input string what, input axi_pkg::axi_data_t got,
                           input axi_pkg::axi_data_t exp);
    checks++;
    assert (got == exp) else begin
        $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        errors++;
        test_errs++;
    end
endtask

// One write, bready held low for stall cycles after bvalid
task automatic bus_write(input axi_pkg::axi_addr_t addr, input axi_pkg::axi_data_t data,
                         input int stall, output axi_pkg::axi_resp_t resp);
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = (stall == 0);
    @(negedge clk);
    while (!bvalid) @(negedge clk);   // Accepted on the edge before
    awvalid = 1'b0;
    wvalid  = 1'b0;
    resp    = bresp;
    for (int i = 0; i < stall; i++) begin
        @(negedge clk);
        assert (bvalid) else begin
            $display("bvalid dropped at %0t ns while bready was held low", $time);
            errors++;
            test_errs++;
        end
    end
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
endtask

task automatic bus_read(input axi_pkg::axi_addr_t addr, output axi_pkg::axi_data_t data,
                        output axi_pkg::axi_resp_t resp);
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    arvalid = 1'b0;
    data    = rdata;
    resp    = rresp;
    @(negedge clk);   // Taken on the edge before
    rready = 1'b0;
endtask

task automatic write_checked(input axi_pkg::axi_addr_t addr, input axi_pkg::axi_data_t data);
    axi_pkg::axi_resp_t resp;
    bus_write(addr, data, 0, resp);
    check_field("write response", 32'(resp), 32'(axi_pkg::RESP_OKAY));
endtask

task automatic end_test(input string name);
    string verdict;
    verdict = (test_errs == 0) ? "ok" : "failed";
    $display("test %0d, %s: %s with %0d errors", tests_run + 1, name, verdict, test_errs);
    tests_run++;
    test_errs = 0;
endtask

task automatic load_palette;
    video_pkg::rgb_t color;
    for (int i = 0; i < 256; i++) begin
        color = 12'($urandom);
        write_checked(axi_pkg::PAL_BASE + 16'(i * 4), 32'(color));
        pal_copy[8'(i)] = color;
    end
endtask

task automatic load_map(input logic flips);
    video_pkg::map_entry_t ent;
    for (int i = 0; i < 1024; i++) begin
        ent = 16'($urandom);
        if (!flips) begin
            ent[15:14] = 2'b00;
        end
        write_checked(axi_pkg::MAP_BASE + 16'(i * 4), 32'(ent));
        map_copy[10'(i)] = ent;
    end
endtask

// Returns after output vsync falls, before the next frame's first pixel
task automatic wait_frame_start;
    @(negedge clk);
    while (!vsync) @(negedge clk);
    while (vsync) @(negedge clk);
endtask

// Hsync starts 8 pixels after the active area ends and lasts 9 pixels
task automatic check_hsync;
    int gap;
    int width;
    gap   = 0;
    width = 0;
    @(negedge clk);
    while (de) @(negedge clk);   // First blanking pixel of the line
    while (!hsync) begin
        gap++;
        @(negedge clk);
    end
    while (hsync) begin
        width++;
        @(negedge clk);
    end
    check_field("hsync start after active end", 32'(gap), 32'd8);
    check_field("hsync width", 32'(width), 32'd9);
endtask

task automatic compare_frame(input video_pkg::coord_t sx, input video_pkg::coord_t sy,
                             input logic on);
    int              idx;
    video_pkg::rgb_t exp;
    idx = 0;
    while (idx < H_ACTIVE * V_ACTIVE) begin
        @(negedge clk);
        if (de) begin
            exp = expected_rgb(idx % H_ACTIVE, idx / H_ACTIVE, sx, sy, on);
            checks++;
            assert (rgb == exp) else begin
                errors++;
                test_errs++;
                if (test_errs <= 10) begin   // Keep the log short
                    $display("mismatch at %0t ns: pixel (%0d,%0d) rgb %h, expected %h",
                             $time, idx % H_ACTIVE, idx / H_ACTIVE, rgb, exp);
                end
            end
            idx++;
        end
    end
endtask

task automatic register_access;
    axi_pkg::axi_addr_t addr [3];
    axi_pkg::axi_data_t mask [3];
    axi_pkg::axi_data_t data;
    axi_pkg::axi_resp_t resp;
    addr = '{axi_pkg::REG_CTRL, axi_pkg::REG_SCROLL_X, axi_pkg::REG_SCROLL_Y};
    mask = '{32'h1, 32'h1FF, 32'h1FF};
    for (int i = 0; i < 3; i++) begin
        data = $urandom;
        write_checked(addr[2'(i)], data);
        reg_expect[2'(i)] = data & mask[2'(i)];
    end
    for (int i = 0; i < 3; i++) begin
        bus_read(addr[2'(i)], data, resp);
        check_field("register read response", 32'(resp), 32'(axi_pkg::RESP_OKAY));
        check_field("register read data", data, reg_expect[2'(i)]);
    end
    end_test("register access");
endtask

task automatic error_responses;
    axi_pkg::axi_data_t data;
    axi_pkg::axi_resp_t resp;
    bus_write(16'h3000, 32'hFFFF_FFFF, 0, resp);
    check_field("unmapped write response", 32'(resp), 32'(axi_pkg::RESP_DECERR));
    bus_read(axi_pkg::MAP_BASE, data, resp);
    check_field("map read response", 32'(resp), 32'(axi_pkg::RESP_SLVERR));
    check_field("map read data", data, 32'd0);
    bus_read(16'h3000, data, resp);
    check_field("unmapped read response", 32'(resp), 32'(axi_pkg::RESP_DECERR));
    check_field("unmapped read data", data, 32'd0);
    bus_read(axi_pkg::REG_SCROLL_X, data, resp);   // Untouched by the bad write
    check_field("scroll x after unmapped write", data, reg_expect[1]);
    bus_write(axi_pkg::REG_SCROLL_Y, reg_expect[2], 6, resp);
    check_field("stalled write response", 32'(resp), 32'(axi_pkg::RESP_OKAY));
    end_test("error responses");
endtask

task automatic plain_frame;
    load_palette();
    load_map(1'b0);
    write_checked(axi_pkg::REG_SCROLL_X, 32'd0);
    write_checked(axi_pkg::REG_SCROLL_Y, 32'd0);
    write_checked(axi_pkg::REG_CTRL, 32'd1);
    wait_frame_start();
    compare_frame(9'd0, 9'd0, 1'b1);
    check_hsync();
    end_test("plain frame");
endtask

task automatic flip_frame;
    load_map(1'b1);
    wait_frame_start();
    compare_frame(9'd0, 9'd0, 1'b1);
    end_test("flips");
endtask

task automatic scroll_wrap;
    wait_frame_start();
    fork
        compare_frame(9'd0, 9'd0, 1'b1);   // Old scroll to the end of this frame
        begin
            repeat (MID_FRAME) @(negedge clk);
            write_checked(axi_pkg::REG_SCROLL_X, 32'd500);
            write_checked(axi_pkg::REG_SCROLL_Y, 32'd497);
        end
    join
    wait_frame_start();
    compare_frame(9'd500, 9'd497, 1'b1);   // Wraps in both directions
    end_test("scroll and wrap");
endtask

task automatic layer_off;
    write_checked(axi_pkg::REG_CTRL, 32'd0);
    wait_frame_start();
    compare_frame(9'd500, 9'd497, 1'b0);
    end_test("layer off");
endtask

`endif

// ==== testbench/tb_scroll_layer.sv ====
// Testbench for the scroll layer
// Clock, reset, graphics ROM model, reference pixel model, timeout and summary
`timescale 1ns/1ns
`default_nettype none

module tb_scroll_layer;

    localparam int H_ACTIVE     = 64;   // Small raster keeps frames short
    localparam int H_TOTAL      = 96;
    localparam int V_ACTIVE     = 32;
    localparam int V_TOTAL      = 40;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;          // 3840
    localparam int TIMEOUT      = 20 * FRAME_CYCLES + 23200;  // 20 frames plus margin
    // From output vsync fall to the middle of the next active area
    localparam int MID_FRAME    = (V_TOTAL - V_ACTIVE - 3 + V_ACTIVE / 2) * H_TOTAL;

    logic                  clk = 1'b0;
    logic                  rst;
    axi_pkg::axi_addr_t    awaddr;
    logic                  awvalid;
    logic                  awready;
    axi_pkg::axi_data_t    wdata;
    logic                  wvalid;
    logic                  wready;
    axi_pkg::axi_resp_t    bresp;
    logic                  bvalid;
    logic                  bready;
    axi_pkg::axi_addr_t    araddr;
    logic                  arvalid;
    logic                  arready;
    axi_pkg::axi_data_t    rdata;
    axi_pkg::axi_resp_t    rresp;
    logic                  rvalid;
    logic                  rready;
    video_pkg::rom_addr_t  rom_addr;
    video_pkg::rom_word_t  rom_data = '0;
    video_pkg::rgb_t       rgb;
    logic                  de;
    logic                  hsync;
    logic                  vsync;

    video_pkg::map_entry_t map_copy [0:1023];   // What the bus wrote
    video_pkg::rgb_t       pal_copy [0:255];
    axi_pkg::axi_data_t    reg_expect [3];      // ctrl, scroll x, scroll y
    int                    errors      = 0;
    int                    test_errs   = 0;
    int                    checks      = 0;
    int                    tests_run   = 0;
    int                    cycle_count = 0;

    scroll_layer #(
        .H_ACTIVE (H_ACTIVE), .H_TOTAL (H_TOTAL),
        .V_ACTIVE (V_ACTIVE), .V_TOTAL (V_TOTAL)
    ) UUT (.*);

    always #10 clk = ~clk;   // 20 ns period

    // Graphics ROM contents, a hash of the word address
    function automatic video_pkg::rom_word_t rom_value(input video_pkg::rom_addr_t addr);
        logic [31:0] prod;
        prod = {16'd0, addr} * 32'h9E37 + 32'h1234;
        return prod[15:0];
    endfunction

    always @(posedge clk) begin
        rom_data <= rom_value(rom_addr);   // One cycle read
    end

    // Reference pixel at screen x, y for one frame's latched settings
    function automatic video_pkg::rgb_t expected_rgb(input int x, input int y,
                                                     input video_pkg::coord_t sx,
                                                     input video_pkg::coord_t sy,
                                                     input logic on);
        video_pkg::coord_t     px;
        video_pkg::coord_t     py;
        video_pkg::map_entry_t ent;
        logic [3:0]            row;
        logic [3:0]            col;
        logic [1:0]            bitpos;
        video_pkg::rom_word_t  word;
        logic [3:0]            p3, p2, p1, p0;
        if (!on) begin
            return pal_copy[255];   // Layer off shows the last entry
        end
        px   = 9'(x) + sx;          // Plane wraps at 512
        py   = 9'(y) + sy;
        ent  = map_copy[{py[8:4], px[8:4]}];
        row  = ent[15] ? 4'd15 - py[3:0] : py[3:0];   // vflip
        col  = ent[14] ? 4'd15 - px[3:0] : px[3:0];   // hflip
        word = rom_value({ent[9:0], row, col[3:2]});
        bitpos = 2'd3 - col[1:0];   // Nibble bit 3 is leftmost
        p3 = word[15:12];
        p2 = word[11:8];
        p1 = word[7:4];
        p0 = word[3:0];
        return pal_copy[{ent[13:10], p3[bitpos], p2[bitpos], p1[bitpos], p0[bitpos]}];
    endfunction

    `include "tb_tasks.svh"

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h4295));      // Single seed for the run
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (3) @(negedge clk);      // Reset over three rising edges
        rst = 1'b0;
        register_access();
        error_responses();
        plain_frame();
        flip_frame();
        scroll_wrap();
        layer_off();
        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
logic/video_pkg.sv
logic/axi_pkg.sv
logic/cpu_regs.sv
logic/scan_counter.sv
logic/tile_map_ram.sv
logic/tile_fetch.sv
logic/tile_pixel.sv
logic/palette_ram.sv
logic/scroll_layer.sv
+incdir+testbench
testbench/tb_scroll_layer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the scroll layer testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_scroll_layer -Mdir obj_dir -f all.f

./obj_dir/Vtb_scroll_layer | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
